// File: Makefile
# Verilator simulation of lspc2Core

SIM = obj_dir/lspc2CoreSim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM): lspc2Core.f *.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module lspc2CoreTb -f lspc2Core.f -o lspc2CoreSim

test: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf obj_dir

// File: cpuRegisters.sv
// CPU register decode, VRAM address and modulo logic, read latch and read data mux
`timescale 1ns/1ps

module cpuRegisters (
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic cpuWrite,
	input logic cpuRead,
	input logic [lspcPkg::regAddrW-1:0] cpuAddr,
	input logic [lspcPkg::vramDataW-1:0] cpuDataIn,
	input logic [videoPkg::rasterW-1:0] rasterCount,
	output logic [lspcPkg::vramDataW-1:0] cpuDataOut,
	output logic vramBusy,
	vramPort.requester vram,
	timerCtrl.source timer
);

	typedef logic [lspcPkg::vramDataW-1:0] wordT;

	logic [lspcPkg::vramAddrW-1:0] vramAddr;
	logic [lspcPkg::vramAddrW-1:0] vramMod;
	wordT readLatch;
	logic loadOnWrite;
	logic waitRd;
	logic wrAddr;
	logic wrRw;

	// Busy from the register write until the access lands
	assign vramBusy = vram.req || waitRd;

	// VRAM-side writes while busy are dropped
	assign wrAddr = cpuWrite && (cpuAddr == lspcPkg::regVramAddr) && !vramBusy;
	assign wrRw = cpuWrite && (cpuAddr == lspcPkg::regVramRw) && !vramBusy;

	// ========================================
	// Control registers
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			vram.req <= 1'b0;
			vram.we <= 1'b0;
			waitRd <= 1'b0;
			vramAddr <= '0;
			vramMod <= '0;
			loadOnWrite <= 1'b0;
			timer.irqEn <= 1'b0;
			timer.reloadAtZero <= 1'b0;
			timer.loadNow <= 1'b0;
			timer.ack <= 1'b0;
		end
		else
		begin
			// Pulses last one cycle
			timer.loadNow <= 1'b0;
			timer.ack <= 1'b0;

			// New address, then prefetch the word at it
			if (wrAddr)
			begin
				vram.req <= 1'b1;
				vram.we <= 1'b0;
				vramAddr <= cpuDataIn[lspcPkg::vramAddrW-1:0];
			end
			// Write at the current address, then step by VRAMMOD
			else if (wrRw)
			begin
				vram.req <= 1'b1;
				vram.we <= 1'b1;
				// Wraps at 2^15 by width
				vramAddr <= vramAddr + vramMod;
			end
			else if (vram.req && vram.gnt)
			begin
				vram.req <= 1'b0;
				// Reads still owe their data
				waitRd <= !vram.we;
			end

			if (waitRd && vram.rvalid)
				waitRd <= 1'b0;

			if (cpuWrite)
			begin
				case (cpuAddr)
					lspcPkg::regVramMod:
						vramMod <= cpuDataIn[lspcPkg::vramAddrW-1:0];
					lspcPkg::regLspcMode:
					begin
						timer.irqEn <= cpuDataIn[lspcPkg::modeIrqEnBit];
						loadOnWrite <= cpuDataIn[lspcPkg::modeLoadOnWriteBit];
						timer.reloadAtZero <= cpuDataIn[lspcPkg::modeReloadAtZeroBit];
					end
					// Low half write completes the reload value
					lspcPkg::regTimerLow:
						timer.loadNow <= loadOnWrite;
					lspcPkg::regIrqAck:
						timer.ack <= cpuDataIn[lspcPkg::ackTimerBit];
					default:
						;
				endcase
			end
		end
	end

	// ========================================
	// Data path
	// ========================================

	always_ff @(posedge CLK_24M)
	begin
		if (wrAddr)
			vram.addr <= cpuDataIn[lspcPkg::vramAddrW-1:0];
		if (wrRw)
		begin
			// Old address goes out, the new one is already stepped
			vram.addr <= vramAddr;
			vram.wdata <= cpuDataIn;
		end

		// Prefetched word for the next VRAMRW read
		if (waitRd && vram.rvalid)
			readLatch <= vram.rdata;

		if (cpuWrite && (cpuAddr == lspcPkg::regTimerHigh))
			timer.reload[lspcPkg::timerW-1:lspcPkg::vramDataW] <= cpuDataIn;
		if (cpuWrite && (cpuAddr == lspcPkg::regTimerLow))
			timer.reload[lspcPkg::vramDataW-1:0] <= cpuDataIn;

		// Read data one cycle after the strobe
		if (cpuRead)
		begin
			case (cpuAddr)
				lspcPkg::regVramRw:
					cpuDataOut <= readLatch;
				// LSPCMODE reads back the raster line
				lspcPkg::regLspcMode:
					cpuDataOut <= wordT'(rasterCount);
				default:
					cpuDataOut <= '0;
			endcase
		end
	end

endmodule

// File: fixFetch.sv
// Fix map address generation, per-line column fetch and P-bus credit counter
`timescale 1ns/1ps

module fixFetch (
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic lineStart,
	input logic [videoPkg::rasterW-1:0] rasterCount,
	vramPort.requester vram,
	output videoPkg::fixEntry entry,
	output logic entryValid,
	input logic creditReturn
);

	typedef logic [lspcPkg::vramAddrW-1:0] addrT;
	typedef logic [videoPkg::rasterW-1:0] rasT;
	typedef logic [videoPkg::creditW-1:0] creditT;
	typedef logic [videoPkg::fixColW-1:0] colT;

	logic [videoPkg::fixColW-1:0] column;
	logic [videoPkg::rasterW-1:0] lineRaster;
	logic [videoPkg::creditW-1:0] credits;
	logic active;
	logic waitRd;
	logic visible;
	logic issue;

	// 256 visible lines after vsync
	assign visible = (rasterCount >= rasT'(videoPkg::vsyncLines))
		&& (rasterCount < rasT'(videoPkg::vsyncLines + 256));

	// One fetch in flight, and only with a free FIFO slot
	// Credit not yet spent while entryValid is high
	assign issue = active && !vram.req && !waitRd && !entryValid && (credits != '0);

	// Read-only port
	assign vram.we = 1'b0;
	assign vram.wdata = '0;

	// Column-major map, tile row from the line number
	assign vram.addr = videoPkg::fixMapBase
		+ addrT'(column) * addrT'(videoPkg::fixRows)
		+ addrT'((lineRaster >> 3) % videoPkg::fixRows);

	// ========================================
	// Fetch sequence and credits
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			vram.req <= 1'b0;
			active <= 1'b0;
			waitRd <= 1'b0;
			column <= '0;
			lineRaster <= '0;
			entryValid <= 1'b0;
			credits <= creditT'(videoPkg::pbusCredits);
		end
		else
		begin
			entryValid <= 1'b0;

			if (issue)
				vram.req <= 1'b1;

			// Grant ends the request, next column
			if (vram.req && vram.gnt)
			begin
				vram.req <= 1'b0;
				waitRd <= 1'b1;
				column <= column + 1'b1;
				if (column == colT'(videoPkg::fixColumns - 1))
					active <= 1'b0;
			end

			// Fetch done, entry out next cycle
			if (waitRd && vram.rvalid)
			begin
				waitRd <= 1'b0;
				entryValid <= 1'b1;
			end

			// Spend on send, refill on pop
			credits <= credits - creditT'(entryValid) + creditT'(creditReturn);

			// New line restarts at column 0
			if (lineStart && visible)
			begin
				active <= 1'b1;
				column <= '0;
				lineRaster <= rasterCount;
			end
		end
	end

	// Tile in the low bits, palette on top
	always_ff @(posedge CLK_24M)
	begin
		if (waitRd && vram.rvalid)
		begin
			entry.tile <= vram.rdata[videoPkg::tileW-1:0];
			entry.pal <= vram.rdata[lspcPkg::vramDataW-1 -: videoPkg::palW];
			entry.line <= lineRaster[videoPkg::lineW-1:0];
		end
	end

endmodule

// File: lspc2Core.f
lspcPkg.sv
videoPkg.sv
lspcIfaces.sv
videoTiming.sv
cpuRegisters.sv
lspcTimer.sv
vramArbiter.sv
fixFetch.sv
pbusSerializer.sv
lspc2Core.sv
lspc2Core_asserts.sv
lspc2Core_tb.sv

// File: lspc2Core.sv
// Top level of the video controller with all blocks and bus instances wired to plain ports
`timescale 1ns/1ps

module lspc2Core (
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic [lspcPkg::regAddrW-1:0] cpuAddr,
	input logic [lspcPkg::vramDataW-1:0] cpuDataIn,
	input logic cpuWrite,
	input logic cpuRead,
	output logic [lspcPkg::vramDataW-1:0] cpuDataOut,
	output logic vramBusy,
	output logic hsync,
	output logic vsync,
	output logic timerIrq,
	output logic [videoPkg::tileW-1:0] pbusTile,
	output logic [videoPkg::palW-1:0] pbusPal,
	output logic [videoPkg::lineW-1:0] pbusLine,
	output logic pbusStrobe
);

	logic pixelTick;
	logic lineStart;
	logic [videoPkg::rasterW-1:0] rasterCount;
	videoPkg::fixEntry fixEntryBus;
	logic entryValid;
	logic creditReturn;

	// ========================================
	// Shared buses
	// ========================================

	// Fix fetch and CPU each get one VRAM port
	vramPort fixBus ();
	vramPort cpuBus ();
	timerCtrl timerBus ();

	videoTiming u_videoTiming (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.pixelTick(pixelTick),
		.lineStart(lineStart),
		.hsync(hsync),
		.vsync(vsync),
		.pixelCount(),
		.rasterCount(rasterCount)
	);

	cpuRegisters u_cpuRegisters (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpuWrite(cpuWrite),
		.cpuRead(cpuRead),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.rasterCount(rasterCount),
		.cpuDataOut(cpuDataOut),
		.vramBusy(vramBusy),
		.vram(cpuBus),
		.timer(timerBus)
	);

	lspcTimer u_lspcTimer (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.pixelTick(pixelTick),
		.timer(timerBus),
		.timerIrq(timerIrq)
	);

	vramArbiter u_vramArbiter (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.fixPort(fixBus),
		.cpuPort(cpuBus)
	);

	// Fetch to serializer under credit flow control
	fixFetch u_fixFetch (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.lineStart(lineStart),
		.rasterCount(rasterCount),
		.vram(fixBus),
		.entry(fixEntryBus),
		.entryValid(entryValid),
		.creditReturn(creditReturn)
	);

	pbusSerializer u_pbusSerializer (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.pixelTick(pixelTick),
		.entry(fixEntryBus),
		.entryValid(entryValid),
		.creditReturn(creditReturn),
		.pbusTile(pbusTile),
		.pbusPal(pbusPal),
		.pbusLine(pbusLine),
		.pbusStrobe(pbusStrobe)
	);

endmodule

// File: lspc2Core_asserts.sv
// Bound concurrent checks on VRAM grants, fetch credits and hsync period
`timescale 1ns/1ps

module lspc2CoreAsserts (
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic fixReq,
	input logic fixGnt,
	input logic cpuReq,
	input logic cpuGnt,
	input logic [videoPkg::creditW-1:0] credits,
	input logic hsync
);

	// Cycles in one full line
	localparam int linePeriod = videoPkg::lineLength * videoPkg::pixelTickDiv;

	int sinceFall;
	logic seenFall;
	logic hsyncD;
	logic hsyncFell;
	// Failed checks so far
	int assertFails = 0;

	assign hsyncFell = hsyncD && !hsync;

	// Cycle count since the last hsync fall
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			sinceFall <= 0;
			seenFall <= 1'b0;
			hsyncD <= 1'b0;
		end
		else
		begin
			hsyncD <= hsync;
			if (hsyncFell)
			begin
				sinceFall <= 0;
				seenFall <= 1'b1;
			end
			else
				sinceFall <= sinceFall + 1;
		end
	end

	// ========================================
	// Arbitration
	// ========================================

	fixGntNeedsReq: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		fixGnt |-> fixReq)
		else
		begin
			$error("fix grant without fix request");
			assertFails++;
		end

	cpuGntNeedsReq: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		cpuGnt |-> cpuReq)
		else
		begin
			$error("CPU grant without CPU request");
			assertFails++;
		end

	oneGrant: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!(fixGnt && cpuGnt))
		else
		begin
			$error("both VRAM ports granted in one cycle");
			assertFails++;
		end

	// ========================================
	// Credits and sync
	// ========================================

	creditBound: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		credits <= videoPkg::creditW'(videoPkg::pbusCredits))
		else
		begin
			$error("fetch credit count above FIFO depth");
			assertFails++;
		end

	hsyncPeriod: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		(hsyncFell && seenFall) |-> (sinceFall == linePeriod - 1))
		else
		begin
			$error("hsync fall spacing differs from one line");
			assertFails++;
		end

endmodule

bind lspc2Core lspc2CoreAsserts u_lspc2CoreAsserts (
	.CLK_24M(CLK_24M),
	.T73A_OUT(T73A_OUT),
	.fixReq(fixBus.req),
	.fixGnt(fixBus.gnt),
	.cpuReq(cpuBus.req),
	.cpuGnt(cpuBus.gnt),
	.credits(u_fixFetch.credits),
	.hsync(hsync)
);

// File: lspc2Core_tb.sv
// Testbench for lspc2Core with VRAM model, raster tracking, P-bus and timer checks
`timescale 1ns/1ps

module lspc2CoreTb;

	localparam int lineCycles = videoPkg::lineLength * videoPkg::pixelTickDiv;
	localparam longint frameCycles = longint'(lineCycles) * videoPkg::linesPerFrame;
	// Up to 8 timer periods of 256 ticks
	localparam longint timerBudget = 8 * 256 * videoPkg::pixelTickDiv;
	localparam longint watchdogCycles = 3 * frameCycles + timerBudget;
	localparam int mapWords = videoPkg::fixColumns * videoPkg::fixRows;

	logic CLK_24M;
	logic T73A_OUT;
	logic [lspcPkg::regAddrW-1:0] cpuAddr;
	logic [lspcPkg::vramDataW-1:0] cpuDataIn;
	logic cpuWrite;
	logic cpuRead;
	logic [lspcPkg::vramDataW-1:0] cpuDataOut;
	logic vramBusy;
	logic hsync;
	logic vsync;
	logic timerIrq;
	logic [videoPkg::tileW-1:0] pbusTile;
	logic [videoPkg::palW-1:0] pbusPal;
	logic [videoPkg::lineW-1:0] pbusLine;
	logic pbusStrobe;

	// Sparse VRAM model and CPU-side address tracking
	logic [15:0] model [int];
	int curAddr;
	int curMod;

	int errors = 0;
	int passCnt = 0;
	int failCnt = 0;
	int cycle = 0;

	// Raster tracking state
	logic prevH = 1'b0;
	logic prevV = 1'b0;
	int tbRaster = 0;
	int lastFall = -1;
	int vFalls = 0;
	int vLow = 0;
	int linesInFrame = 0;
	int strobeCol = 0;
	int strobeChecks = 0;
	logic mapLoaded = 1'b0;
	logic checkOn = 1'b0;

	lspc2Core u_lspc2Core (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.cpuWrite(cpuWrite),
		.cpuRead(cpuRead),
		.cpuDataOut(cpuDataOut),
		.vramBusy(vramBusy),
		.hsync(hsync),
		.vsync(vsync),
		.timerIrq(timerIrq),
		.pbusTile(pbusTile),
		.pbusPal(pbusPal),
		.pbusLine(pbusLine),
		.pbusStrobe(pbusStrobe)
	);

	// 4 ns clock
	always #2 CLK_24M = ~CLK_24M;

	always @(posedge CLK_24M)
		cycle <= cycle + 1;

	// ========================================
	// Helpers
	// ========================================

	function automatic logic visibleLine(input int r);
		return (r >= videoPkg::vsyncLines) && (r < videoPkg::vsyncLines + 256);
	endfunction

	function automatic int mapAddr(input int col, input int r);
		return int'(videoPkg::fixMapBase) + col * videoPkg::fixRows
			+ ((r / 8) % videoPkg::fixRows);
	endfunction

	// Wait out a VRAM access within a cycle limit
	task automatic waitIdle();
		int n;
		n = 0;
		while (vramBusy && n < 200)
		begin
			@(posedge CLK_24M);
			#1;
			n++;
		end
		if (vramBusy)
		begin
			$display("ERROR at %0t: vramBusy never dropped", $time);
			errors++;
		end
	endtask

	// One-cycle register write entered 1 ns after an edge
	task automatic writeReg(input logic [2:0] a, input logic [15:0] d);
		cpuAddr = a;
		cpuDataIn = d;
		cpuWrite = 1'b1;
		@(posedge CLK_24M);
		#1;
		cpuWrite = 1'b0;
		if (a == lspcPkg::regVramAddr || a == lspcPkg::regVramRw)
			waitIdle();
	endtask

	// Read one register and the raster line tracked at the sampling edge
	task automatic readReg(input logic [2:0] a, output logic [15:0] d, output int r);
		cpuAddr = a;
		cpuRead = 1'b1;
		@(posedge CLK_24M);
		#1;
		cpuRead = 1'b0;
		d = cpuDataOut;
		r = tbRaster;
	endtask

	task automatic setAddr(input int a);
		writeReg(lspcPkg::regVramAddr, 16'(a));
		curAddr = a;
	endtask

	task automatic setMod(input int m);
		writeReg(lspcPkg::regVramMod, 16'(m));
		curMod = m;
	endtask

	// Write at the tracked address, then step like VRAMMOD
	task automatic vramWrite(input logic [15:0] d);
		writeReg(lspcPkg::regVramRw, d);
		model[curAddr] = d;
		curAddr = (curAddr + curMod) % lspcPkg::vramWords;
	endtask

	task automatic readBack(input int a);
		logic [15:0] d;
		int r;
		setAddr(a);
		readReg(lspcPkg::regVramRw, d, r);
		assert (d == model[a])
		else
		begin
			$display("MISMATCH at %0t: VRAM[%h] read %h, expected %h", $time, a, d, model[a]);
			errors++;
		end
	endtask

	task automatic finishTest(input string name, input int errStart);
		if (errors == errStart)
		begin
			passCnt++;
			$display("Test %s: ok", name);
		end
		else
		begin
			failCnt++;
			$display("Test %s: %0d errors", name, errors - errStart);
		end
	endtask

	// ========================================
	// Raster and P-bus monitor
	// ========================================

	// Tracks sync, raster line and strobes on the falling edge
	always @(negedge CLK_24M)
	begin
		if (T73A_OUT)
		begin
			if (prevH && !hsync)
			begin
				if (lastFall >= 0)
					assert (cycle - lastFall == lineCycles)
					else
					begin
						$display("MISMATCH at %0t: line took %0d cycles", $time, cycle - lastFall);
						errors++;
					end
				lastFall = cycle;
				// Every visible line sends the full column count
				if (checkOn && visibleLine(tbRaster))
					assert (strobeCol == videoPkg::fixColumns)
					else
					begin
						$display("MISMATCH at %0t: line %0d had %0d strobes",
							$time, tbRaster, strobeCol);
						errors++;
					end
				// New frame
				if (prevV && !vsync)
				begin
					if (vFalls > 0)
						assert (linesInFrame == videoPkg::linesPerFrame)
						else
						begin
							$display("MISMATCH at %0t: frame had %0d lines", $time, linesInFrame);
							errors++;
						end
					vFalls++;
					tbRaster = 0;
					linesInFrame = 1;
					vLow = 0;
					if (mapLoaded)
						checkOn = 1'b1;
				end
				else
				begin
					tbRaster = (tbRaster + 1) % videoPkg::linesPerFrame;
					linesInFrame++;
				end
				if (!vsync)
					vLow++;
				strobeCol = 0;
			end
			if (!prevV && vsync && vFalls > 0)
				assert (vLow == videoPkg::vsyncLines)
				else
				begin
					$display("MISMATCH at %0t: vsync low for %0d lines", $time, vLow);
					errors++;
				end
			if (pbusStrobe && checkOn)
			begin
				if (!visibleLine(tbRaster) || strobeCol >= videoPkg::fixColumns)
				begin
					$display("ERROR at %0t: unexpected strobe on line %0d", $time, tbRaster);
					errors++;
				end
				else
				begin
					assert ({pbusPal, pbusTile} == model[mapAddr(strobeCol, tbRaster)]
						&& pbusLine == 3'(tbRaster))
					else
					begin
						$display("MISMATCH at %0t: line %0d col %0d got %h/%h/%0d",
							$time, tbRaster, strobeCol, pbusTile, pbusPal, pbusLine);
						errors++;
					end
					strobeChecks++;
				end
				strobeCol++;
			end
			prevH = hsync;
			prevV = vsync;
		end
	end

	// Watchdog from frame length and timer budget
	initial
	begin
		#(watchdogCycles * 4);
		$display("Timeout: simulation ran past its time budget");
		$display("*** FAILED ***");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================

	initial
	begin
		int e;
		int q[$];
		int reload;
		int c0;
		int c1;
		int r;
		int n;
		logic [15:0] d;

		void'($urandom(32'h2964));
		CLK_24M = 1'b0;
		T73A_OUT = 1'b0;
		cpuAddr = '0;
		cpuDataIn = '0;
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		curAddr = 0;
		curMod = 0;
		repeat (4) @(posedge CLK_24M);
		#1;
		T73A_OUT = 1'b1;
		@(posedge CLK_24M);
		#1;

		// Random modulo writes wrapping past the top of VRAM
		e = errors;
		setMod($urandom_range(1, 2047) | 1);
		setAddr(15'h7FF0);
		for (int i = 0; i < 24; i++)
		begin
			q.push_back(curAddr);
			vramWrite(16'($urandom));
		end
		foreach (q[i])
			readBack(q[i]);
		finishTest("vram modulo write/read", e);

		// Fill the fix map, then check one whole frame of strobes
		e = errors;
		setMod(1);
		setAddr(int'(videoPkg::fixMapBase));
		for (int i = 0; i < mapWords; i++)
			vramWrite(16'($urandom));
		mapLoaded = 1'b1;
		while (!checkOn)
			@(negedge CLK_24M);
		n = vFalls;
		while (vFalls == n)
			@(negedge CLK_24M);
		if (strobeChecks == 0)
		begin
			$display("ERROR: no P-bus strobes were seen");
			errors++;
		end
		finishTest("fix fetch on P-bus", e);

		// CPU traffic below the fix map while the fetch runs
		e = errors;
		while (!vsync)
			@(negedge CLK_24M);
		while (hsync)
			@(negedge CLK_24M);
		@(posedge CLK_24M);
		#1;
		q.delete();
		setMod($urandom_range(1, 255));
		setAddr($urandom_range(0, 16'h6000));
		for (int i = 0; i < 8; i++)
		begin
			q.push_back(curAddr);
			vramWrite(16'($urandom));
		end
		foreach (q[i])
			readBack(q[i]);
		finishTest("cpu access during fetch", e);

		// Sync checks run in the monitor for every line
		e = errors;
		if (vFalls < 2)
		begin
			$display("ERROR: no complete frame was observed");
			errors++;
		end
		finishTest("hsync and vsync timing", e);

		// Timer with reload at zero
		e = errors;
		reload = $urandom_range(16, 255);
		writeReg(lspcPkg::regTimerHigh, 16'h0);
		writeReg(lspcPkg::regTimerLow, 16'(reload));
		writeReg(lspcPkg::regLspcMode, 16'((1 << lspcPkg::modeIrqEnBit)
			| (1 << lspcPkg::modeLoadOnWriteBit) | (1 << lspcPkg::modeReloadAtZeroBit)));
		writeReg(lspcPkg::regTimerLow, 16'(reload));
		n = 0;
		while (!timerIrq && n < 2048)
		begin
			@(negedge CLK_24M);
			n++;
		end
		c0 = cycle;
		for (int k = 0; k < 3; k++)
		begin
			@(posedge CLK_24M);
			#1;
			writeReg(lspcPkg::regIrqAck, 16'(1 << lspcPkg::ackTimerBit));
			@(posedge CLK_24M);
			#1;
			n = 0;
			while (!timerIrq && n < 2048)
			begin
				@(negedge CLK_24M);
				n++;
			end
			c1 = cycle;
			assert (c1 - c0 == (reload + 1) * videoPkg::pixelTickDiv)
			else
			begin
				$display("MISMATCH at %0t: IRQ period %0d cycles, expected %0d",
					$time, c1 - c0, (reload + 1) * videoPkg::pixelTickDiv);
				errors++;
			end
			c0 = c1;
		end
		// Flag stays low with the enable cleared
		@(posedge CLK_24M);
		#1;
		writeReg(lspcPkg::regLspcMode, 16'((1 << lspcPkg::modeLoadOnWriteBit)
			| (1 << lspcPkg::modeReloadAtZeroBit)));
		writeReg(lspcPkg::regIrqAck, 16'(1 << lspcPkg::ackTimerBit));
		@(posedge CLK_24M);
		#1;
		for (int i = 0; i < 3 * (reload + 1) * videoPkg::pixelTickDiv; i++)
		begin
			@(negedge CLK_24M);
			assert (!timerIrq)
			else
			begin
				$display("MISMATCH at %0t: timerIrq rose with the enable cleared", $time);
				errors++;
			end
		end
		finishTest("raster timer interrupt", e);

		// Raster line readback
		e = errors;
		for (int i = 0; i < 6; i++)
		begin
			repeat ($urandom_range(100, 3000)) @(posedge CLK_24M);
			#1;
			readReg(lspcPkg::regLspcMode, d, r);
			assert (int'(d) == r)
			else
			begin
				$display("MISMATCH at %0t: raster read %0d, expected %0d", $time, d, r);
				errors++;
			end
		end
		finishTest("raster readback", e);

		$display("Tests passed: %0d, failed: %0d", passCnt, failCnt);
		if (errors == 0 && failCnt == 0
			&& u_lspc2Core.u_lspc2CoreAsserts.assertFails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: lspcIfaces.sv
// Interfaces vramPort and timerCtrl with their modports
`timescale 1ns/1ps

// ========================================
// Video RAM request port
// ========================================

// Requester holds req and fields until gnt
// Read data follows with rvalid one cycle after gnt
interface vramPort;
	logic req;
	logic we;
	logic [lspcPkg::vramAddrW-1:0] addr;
	logic [lspcPkg::vramDataW-1:0] wdata;
	logic gnt;
	logic rvalid;
	logic [lspcPkg::vramDataW-1:0] rdata;

	modport requester (
		output req, we, addr, wdata,
		input gnt, rvalid, rdata
	);

	modport arbiter (
		input req, we, addr, wdata,
		output gnt, rvalid, rdata
	);
endinterface

// ========================================
// Timer control from the register block
// ========================================

// loadNow and ack are single-cycle pulses
interface timerCtrl;
	logic [lspcPkg::timerW-1:0] reload;
	logic loadNow;
	logic irqEn;
	logic reloadAtZero;
	logic ack;

	modport source (output reload, loadNow, irqEn, reloadAtZero, ack);
	modport sink (input reload, loadNow, irqEn, reloadAtZero, ack);
endinterface

// File: lspcPkg.sv
// Register map, video RAM geometry, LSPCMODE bits and timer width
package lspcPkg;

	// ========================================
	// Video RAM geometry
	// ========================================

	// Word address, 32K words
	localparam int vramAddrW = 15;
	localparam int vramDataW = 16;
	localparam int vramWords = 32768;

	// ========================================
	// CPU register window
	// ========================================

	// Word index on the CPU address lines
	localparam int regAddrW = 3;

	localparam logic [regAddrW-1:0] regVramAddr = 3'd0;
	localparam logic [regAddrW-1:0] regVramRw = 3'd1;
	localparam logic [regAddrW-1:0] regVramMod = 3'd2;
	localparam logic [regAddrW-1:0] regLspcMode = 3'd3;
	localparam logic [regAddrW-1:0] regTimerHigh = 3'd4;
	localparam logic [regAddrW-1:0] regTimerLow = 3'd5;
	localparam logic [regAddrW-1:0] regIrqAck = 3'd6;

	// LSPCMODE write bits
	localparam int modeIrqEnBit = 4;
	localparam int modeLoadOnWriteBit = 5;
	localparam int modeReloadAtZeroBit = 7;

	// Timer source in the IRQ acknowledge word
	localparam int ackTimerBit = 1;

	// Raster timer, written as two 16-bit halves
	localparam int timerW = 32;

endpackage

// File: lspcTimer.sv
// Raster timer down-counter with load, reload at zero and sticky interrupt flag
`timescale 1ns/1ps

module lspcTimer (
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic pixelTick,
	timerCtrl.sink timer,
	output logic timerIrq
);

	typedef logic [lspcPkg::timerW-1:0] countT;

	logic [lspcPkg::timerW-1:0] count;
	logic hitZero;

	// Counter steps from 1 to 0 on this tick
	assign hitZero = pixelTick && !timer.loadNow && (count == countT'(1));

	// ========================================
	// Counter
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			count <= '0;
			timerIrq <= 1'b0;
		end
		else
		begin
			// CPU load wins over counting
			if (timer.loadNow)
				count <= timer.reload;
			else if (pixelTick)
			begin
				if (count != '0)
					count <= count - 1'b1;
				// One tick spent at zero, then reload
				// gives a period of reload + 1
				else if (timer.reloadAtZero)
					count <= timer.reload;
			end

			// Sticky flag, a new hit beats the ack
			if (hitZero && timer.irqEn)
				timerIrq <= 1'b1;
			else if (timer.ack)
				timerIrq <= 1'b0;
		end
	end

endmodule

// File: pbusSerializer.sv
// Fix entry FIFO, 8-pixel P-bus output slots and credit return
`timescale 1ns/1ps

module pbusSerializer (
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic pixelTick,
	input videoPkg::fixEntry entry,
	input logic entryValid,
	output logic creditReturn,
	output logic [videoPkg::tileW-1:0] pbusTile,
	output logic [videoPkg::palW-1:0] pbusPal,
	output logic [videoPkg::lineW-1:0] pbusLine,
	output logic pbusStrobe
);

	typedef logic [videoPkg::fifoPtrW-1:0] ptrT;
	typedef logic [videoPkg::creditW-1:0] fillT;

	videoPkg::fixEntry fifo [videoPkg::pbusCredits];
	logic [videoPkg::fifoPtrW-1:0] wrPtr;
	logic [videoPkg::fifoPtrW-1:0] rdPtr;
	logic [videoPkg::creditW-1:0] fill;
	// Pixel ticks within one 8-pixel slot
	logic [2:0] slotCnt;
	logic pop;

	function automatic ptrT nextPtr(input ptrT p);
		return (p == ptrT'(videoPkg::pbusCredits - 1)) ? '0 : p + 1'b1;
	endfunction

	// Pop at the end of a slot when there is something
	assign pop = pixelTick && (slotCnt == 3'd7) && (fill != '0);

	// ========================================
	// FIFO pointers and slot timing
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			slotCnt <= '0;
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			pbusStrobe <= 1'b0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (pixelTick)
				slotCnt <= slotCnt + 1'b1;
			// Credits on the fetch side keep this from overflowing
			if (entryValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			fill <= fill + fillT'(entryValid) - fillT'(pop);
			// Strobe and credit leave together
			pbusStrobe <= pop;
			creditReturn <= pop;
		end
	end

	// Outputs hold the last entry between strobes
	always_ff @(posedge CLK_24M)
	begin
		if (entryValid)
			fifo[wrPtr] <= entry;
		if (pop)
		begin
			pbusTile <= fifo[rdPtr].tile;
			pbusPal <= fifo[rdPtr].pal;
			pbusLine <= fifo[rdPtr].line;
		end
	end

endmodule

// File: videoPkg.sv
// Raster timing, fix map layout, fix entry type and P-bus credit depth
package videoPkg;

	// ========================================
	// Raster timing
	// ========================================

	// 24 MHz / 4 gives the 6 MHz pixel rate
	localparam int pixelTickDiv = 4;
	localparam int divW = $clog2(pixelTickDiv);
	localparam int lineLength = 384;
	localparam int linesPerFrame = 264;
	localparam int activeWidth = 320;
	localparam int hsyncWidth = 32;
	localparam int vsyncLines = 8;
	localparam int pixelW = 9;
	localparam int rasterW = 9;

	// ========================================
	// Fix layer
	// ========================================

	// Fix map sits in the upper part of video RAM, column-major
	localparam logic [lspcPkg::vramAddrW-1:0] fixMapBase = 15'h7000;
	localparam int fixRows = 32;
	// One map word per 8-pixel column of the visible line
	localparam int fixColumns = activeWidth / 8;
	localparam int fixColW = $clog2(fixColumns);

	localparam int tileW = 12;
	localparam int palW = 4;
	localparam int lineW = 3;

	// What goes out on the P-bus for one column
	typedef struct packed {
		logic [tileW-1:0] tile;
		logic [palW-1:0] pal;
		logic [lineW-1:0] line;
	} fixEntry;

	// Serializer FIFO depth, also the fetch side's starting credit
	localparam int pbusCredits = 4;
	localparam int creditW = $clog2(pbusCredits + 1);
	localparam int fifoPtrW = $clog2(pbusCredits);

endpackage

// File: videoTiming.sv
// Pixel tick divider, pixel and raster counters, sync and line start decode
`timescale 1ns/1ps

module videoTiming (
	input logic CLK_24M,
	input logic T73A_OUT,
	output logic pixelTick,
	output logic lineStart,
	output logic hsync,
	output logic vsync,
	output logic [videoPkg::pixelW-1:0] pixelCount,
	output logic [videoPkg::rasterW-1:0] rasterCount
);

	typedef logic [videoPkg::divW-1:0] divT;
	typedef logic [videoPkg::pixelW-1:0] pixT;
	typedef logic [videoPkg::rasterW-1:0] rasT;

	logic [videoPkg::divW-1:0] divCnt;
	logic lastPixel;
	logic lastLine;

	// Tick on the last 24M cycle of each pixel
	assign pixelTick = (divCnt == divT'(videoPkg::pixelTickDiv - 1));
	assign lastPixel = (pixelCount == pixT'(videoPkg::lineLength - 1));
	assign lastLine = (rasterCount == rasT'(videoPkg::linesPerFrame - 1));

	// Line start marks the tick of pixel 0
	assign lineStart = pixelTick && (pixelCount == '0);

	// Both syncs active low at the start of their period
	assign hsync = !(pixelCount < pixT'(videoPkg::hsyncWidth));
	assign vsync = !(rasterCount < rasT'(videoPkg::vsyncLines));

	// ========================================
	// Counters
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			divCnt <= '0;
			pixelCount <= '0;
			rasterCount <= '0;
		end
		else
		begin
			divCnt <= pixelTick ? '0 : divCnt + 1'b1;
			if (pixelTick)
			begin
				if (lastPixel)
				begin
					pixelCount <= '0;
					// Frame wrap after the last raster line
					rasterCount <= lastLine ? '0 : rasterCount + 1'b1;
				end
				else
				begin
					pixelCount <= pixelCount + 1'b1;
				end
			end
		end
	end

endmodule

// File: vramArbiter.sv
// Video RAM array with fixed-priority arbitration between fix fetch and CPU ports
`timescale 1ns/1ps

module vramArbiter (
	input logic CLK_24M,
	input logic T73A_OUT,
	vramPort.arbiter fixPort,
	vramPort.arbiter cpuPort
);

	logic [lspcPkg::vramDataW-1:0] mem [lspcPkg::vramWords];
	logic [lspcPkg::vramDataW-1:0] rdataReg;
	logic [lspcPkg::vramDataW-1:0] selWdata;
	logic [lspcPkg::vramAddrW-1:0] selAddr;
	logic fixGnt;
	logic cpuGnt;
	logic anyGnt;
	logic selWe;

	// ========================================
	// Grant, fix port first
	// ========================================

	// Same-cycle grant, one port at most
	assign fixGnt = fixPort.req;
	assign cpuGnt = cpuPort.req && !fixPort.req;
	assign anyGnt = fixGnt || cpuGnt;
	assign fixPort.gnt = fixGnt;
	assign cpuPort.gnt = cpuGnt;

	// Single RAM port follows the winner
	assign selAddr = fixGnt ? fixPort.addr : cpuPort.addr;
	assign selWe = fixGnt ? fixPort.we : cpuPort.we;
	assign selWdata = fixGnt ? fixPort.wdata : cpuPort.wdata;

	// Only one read per cycle, so one data register serves both
	assign fixPort.rdata = rdataReg;
	assign cpuPort.rdata = rdataReg;

	// ========================================
	// RAM access
	// ========================================

	always_ff @(posedge CLK_24M)
	begin
		if (anyGnt && selWe)
			mem[selAddr] <= selWdata;
		if (anyGnt && !selWe)
			rdataReg <= mem[selAddr];
	end

	// rvalid one cycle after a read grant
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			fixPort.rvalid <= 1'b0;
			cpuPort.rvalid <= 1'b0;
		end
		else
		begin
			fixPort.rvalid <= fixGnt && !fixPort.we;
			cpuPort.rvalid <= cpuGnt && !cpuPort.we;
		end
	end

endmodule
